/* hw/cart_pkg.sv */
`default_nettype none

package cart_pkg;

	// ============================================================
	// Header selection and region
	// ============================================================

	typedef enum logic [2:0] {
		HDR_AUTO,
		HDR_NONE,
		HDR_LOROM,
		HDR_HIROM,
		HDR_EXHIROM
	} hdr_mode_t;

	// Auto takes the region bit from the header
	typedef enum logic [1:0] {
		REGION_AUTO,
		REGION_NTSC,
		REGION_PAL
	} region_sel_t;

	// ============================================================
	// Header word, decoded two ways
	// ============================================================

	typedef struct packed {
		logic [7:0] rom_type;
		logic [3:0] ram_size;
		logic [3:0] rom_size;
	} copier_view_t;

	// ROM size lives in the word at the header offset, RAM size two bytes on
	typedef struct packed {
		logic [3:0] hi_rsvd;
		logic [3:0] rom_size;
		logic [3:0] lo_rsvd;
		logic [3:0] ram_size;
	} internal_view_t;

	typedef union packed {
		copier_view_t   copier;
		internal_view_t internal;
	} hdr_word_u;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	// Console side of the battery RAM
	typedef struct packed {
		logic [19:0] addr;
		logic [7:0]  data;
		logic        we;
	} bsram_port_t;

	localparam logic [24:0] COPIER_LEN  = 25'd512;
	localparam logic [24:0] LOROM_HDR   = 25'h007FD6 + COPIER_LEN;
	localparam logic [24:0] HIROM_HDR   = 25'h00FFD6 + COPIER_LEN;
	localparam logic [24:0] EXHIROM_HDR = 25'h40FFD6 + COPIER_LEN;
	localparam logic [24:0] HDR_RAM_OFS = 25'd2;

	localparam logic [3:0]  DEFAULT_ROM_SIZE = 4'hC;
	localparam logic [23:0] MASK_UNIT        = 24'd1024;

	function automatic logic [23:0] rom_mask_of(input logic [3:0] size);
		return (MASK_UNIT << size) - 24'd1;
	endfunction

	// No RAM at all when the size field is zero
	function automatic logic [23:0] ram_mask_of(input logic [3:0] size);
		return (size == 4'd0) ? 24'd0 : (MASK_UNIT << size) - 24'd1;
	endfunction

endpackage

`default_nettype wire

/* hw/link_pkg.sv */
`default_nettype none

package link_pkg;

	// ============================================================
	// Host download stream
	// ============================================================

	// addr is a byte address, one 16-bit word per write
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_word_t;

	// Download index reserved for cheat files
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// Flags sit on top, replace value at the bottom
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ============================================================
	// SD sector requests
	// ============================================================

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	localparam int SECTOR_WORDS  = 256;
	localparam int SECTOR_ADDR_W = $clog2(SECTOR_WORDS);

endpackage

`default_nettype wire

/* hw/download_port.sv */
`timescale 1ns/1ps
`default_nettype none

module download_port (
	input  logic               clk_sys,
	input  logic               RESET,
	input  link_pkg::dl_word_t dl,
	input  logic [7:0]         dl_index,
	input  logic               dl_active,
	output link_pkg::dl_word_t cart_dl,
	output link_pkg::dl_word_t code_dl,
	output logic               cart_busy,
	output logic               cart_start,
	output logic               cart_end
);

	logic        is_code;
	logic        cart_was_busy;
	logic        cart_wr;
	logic        code_wr;
	logic [24:0] addr_q;
	logic [15:0] data_q;

	// The only place that looks at the download index
	assign is_code = (dl_index == link_pkg::CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_busy     <= 1'b0;
			cart_was_busy <= 1'b0;
			cart_wr       <= 1'b0;
			code_wr       <= 1'b0;
		end else begin
			cart_busy     <= dl_active & ~is_code;
			cart_was_busy <= cart_busy;
			cart_wr       <= dl.wr & dl_active & ~is_code;
			code_wr       <= dl.wr & dl_active & is_code;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= dl.addr;
		data_q <= dl.data;
	end

	// Both streams share address and data, only the strobe differs
	assign cart_dl = '{addr: addr_q, data: data_q, wr: cart_wr};
	assign code_dl = '{addr: addr_q, data: data_q, wr: code_wr};

	assign cart_start = cart_busy & ~cart_was_busy;
	assign cart_end   = ~cart_busy & cart_was_busy;

endmodule

`default_nettype wire

/* hw/rom_header_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  link_pkg::dl_word_t     cart_dl,
	input  logic                   cart_busy,
	input  cart_pkg::hdr_mode_t    hdr_mode,
	input  cart_pkg::region_sel_t  region_sel,
	output cart_pkg::cart_info_t   cart_info
);

	cart_pkg::hdr_word_u hdr_word;

	logic        hdr_forced;
	logic [24:0] hdr_base;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [3:0]  rom_size_n;
	logic [3:0]  ram_size_n;
	logic [7:0]  rom_type_n;
	logic        rom_region_n;

	assign hdr_word = cart_dl.data;

	// Where the internal header sits for a forced mode
	always_comb begin
		hdr_forced = 1'b1;
		case (hdr_mode)
			cart_pkg::HDR_LOROM:   hdr_base = cart_pkg::LOROM_HDR;
			cart_pkg::HDR_HIROM:   hdr_base = cart_pkg::HIROM_HDR;
			cart_pkg::HDR_EXHIROM: hdr_base = cart_pkg::EXHIROM_HDR;
			default: begin
				hdr_forced = 1'b0;
				hdr_base   = 25'd0;
			end
		endcase
	end

	// ============================================================
	// Next header state from the current write
	// ============================================================

	always_comb begin
		rom_size_n   = rom_size;
		ram_size_n   = ram_size;
		rom_type_n   = cart_info.rom_type;
		rom_region_n = rom_region;

		if (cart_dl.wr) begin
			if (cart_dl.addr == 25'd0) begin
				rom_size_n = cart_pkg::DEFAULT_ROM_SIZE;
				ram_size_n = 4'd0;
				// Copier header only counts in auto mode with a size byte
				if (hdr_mode == cart_pkg::HDR_AUTO && cart_dl.data[7:0] != 8'd0) begin
					rom_size_n = hdr_word.copier.rom_size;
					ram_size_n = hdr_word.copier.ram_size;
				end
				case (hdr_mode)
					cart_pkg::HDR_NONE,
					cart_pkg::HDR_LOROM:   rom_type_n = 8'd0;
					cart_pkg::HDR_HIROM:   rom_type_n = 8'd1;
					cart_pkg::HDR_EXHIROM: rom_type_n = 8'd2;
					default:               rom_type_n = hdr_word.copier.rom_type;
				endcase
			end

			if (cart_dl.addr == 25'd2) begin
				rom_region_n = cart_dl.data[8];
			end

			if (hdr_forced && cart_dl.addr == hdr_base) begin
				rom_size_n = hdr_word.internal.rom_size;
			end
			if (hdr_forced && cart_dl.addr == hdr_base + cart_pkg::HDR_RAM_OFS) begin
				ram_size_n = hdr_word.internal.ram_size;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size           <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size           <= 4'd0;
			rom_region         <= 1'b0;
			cart_info.rom_type <= 8'd0;
			cart_info.rom_mask <= cart_pkg::rom_mask_of(cart_pkg::DEFAULT_ROM_SIZE);
			cart_info.ram_mask <= 24'd0;
			cart_info.pal      <= 1'b0;
		end else begin
			rom_size           <= rom_size_n;
			ram_size           <= ram_size_n;
			rom_region         <= rom_region_n;
			cart_info.rom_type <= rom_type_n;
			cart_info.rom_mask <= cart_pkg::rom_mask_of(rom_size_n);
			cart_info.ram_mask <= cart_pkg::ram_mask_of(ram_size_n);
			// Region is frozen while a cartridge streams in
			if (!cart_busy) begin
				if (region_sel == cart_pkg::REGION_AUTO) begin
					cart_info.pal <= rom_region;
				end else begin
					cart_info.pal <= (region_sel == cart_pkg::REGION_PAL);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/cheat_code_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  link_pkg::dl_word_t    code_dl,
	output link_pkg::cheat_code_t cheat,
	output logic                  cheat_valid
);

	logic [3:0] ofs;

	// Position inside the 16-byte record
	assign ofs = code_dl.addr[3:0];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_dl.wr && ofs == 4'd14;
		end
	end

	// ============================================================
	// Record fields, bottom word first
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (code_dl.wr) begin
			case (ofs)
				4'd0:  cheat.flags[15:0]    <= code_dl.data;
				4'd2:  cheat.flags[31:16]   <= code_dl.data;
				4'd4:  cheat.addr[15:0]     <= code_dl.data;
				4'd6:  cheat.addr[31:16]    <= code_dl.data;
				4'd8:  cheat.compare[15:0]  <= code_dl.data;
				4'd10: cheat.compare[31:16] <= code_dl.data;
				4'd12: cheat.replace[15:0]  <= code_dl.data;
				// Last word completes the record
				4'd14: cheat.replace[31:16] <= code_dl.data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/backup_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module backup_ram #(
	parameter int BSRAM_ADDR_W = 17
) (
	input  logic                               clk_sys,
	input  link_pkg::dl_word_t                 cart_dl,
	input  logic                               cart_busy,
	input  cart_pkg::bsram_port_t              bsram,
	output logic [7:0]                         bsram_q,
	input  logic [31:0]                        sd_lba,
	input  logic                               sd_ack,
	input  logic [link_pkg::SECTOR_ADDR_W-1:0] sd_buff_addr,
	input  logic [15:0]                        sd_buff_dout,
	input  logic                               sd_buff_wr,
	output logic [15:0]                        sd_buff_din
);

	localparam int WORD_ADDR_W = BSRAM_ADDR_W - 1;
	localparam int LBA_BITS    = WORD_ADDR_W - link_pkg::SECTOR_ADDR_W;

	// Byte 0 of each word in the low half
	logic [1:0][7:0] mem [2**WORD_ADDR_W];

	logic [BSRAM_ADDR_W-1:0] addr_a;
	logic [7:0]              data_a;
	logic                    we_a;
	logic [WORD_ADDR_W-1:0]  addr_b;

	// Download wipes the RAM to FF at every address it passes
	always_comb begin
		if (cart_busy) begin
			addr_a = cart_dl.addr[BSRAM_ADDR_W-1:0];
			data_a = 8'hFF;
			we_a   = cart_dl.wr;
		end else begin
			addr_a = bsram.addr[BSRAM_ADDR_W-1:0];
			data_a = bsram.data;
			we_a   = bsram.we;
		end
	end

	assign addr_b = {sd_lba[LBA_BITS-1:0], sd_buff_addr};

	// Byte-wide console port
	always @(posedge clk_sys) begin
		if (we_a) begin
			mem[addr_a[BSRAM_ADDR_W-1:1]][addr_a[0]] <= data_a;
		end
		bsram_q <= mem[addr_a[BSRAM_ADDR_W-1:1]][addr_a[0]];
	end

	// Word-wide sector buffer port
	always @(posedge clk_sys) begin
		if (sd_buff_wr && sd_ack) begin
			mem[addr_b] <= sd_buff_dout;
		end
		sd_buff_din <= mem[addr_b];
	end

endmodule

`default_nettype wire

/* hw/backup_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_busy,
	input  logic              cart_start,
	input  logic              cart_end,
	input  logic [23:0]       ram_mask,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_size_nz,
	input  logic              bk_load,
	input  logic              bk_save,
	input  logic              autosave,
	input  logic              osd_status,
	input  logic              bsram_we,
	input  logic              sd_ack,
	output link_pkg::sd_req_t sd_req,
	output logic              bk_ena,
	output logic              bk_pending,
	output logic              bk_busy
);

	logic        save_req;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        load_rise;
	logic        save_rise;
	logic        auto_load;
	logic        loading;
	logic [31:0] last_lba;

	// Autosave fires when the OSD opens with unsaved writes
	assign save_req  = bk_save | (autosave & bk_pending & osd_status);
	assign load_rise = bk_load & ~old_load & bk_ena;
	assign save_rise = save_req & ~old_save & bk_ena;
	assign auto_load = cart_end & img_size_nz & bk_ena;

	// One sector per 512 bytes of RAM
	assign last_lba = {17'd0, ram_mask[23:9]};

	// ============================================================
	// Enable and pending flags
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (cart_start) begin
				bk_ena <= 1'b0;
			end
			// Image is already mounted by the time the download finishes
			if (cart_busy && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end

			if (bk_ena && !osd_status && bsram_we) begin
				bk_pending <= 1'b1;
			end else if (bk_busy) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ============================================================
	// Sector transfer machine
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_busy    <= 1'b0;
			loading    <= 1'b0;
			sd_req.lba <= 32'd0;
			sd_req.rd  <= 1'b0;
			sd_req.wr  <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= save_req;
			old_ack  <= sd_ack;

			// Host has taken the request
			if (sd_ack && !old_ack) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_rise || save_rise) begin
					bk_busy    <= 1'b1;
					loading    <= load_rise;
					sd_req.lba <= 32'd0;
					sd_req.rd  <= load_rise;
					sd_req.wr  <= ~load_rise;
				end
				if (auto_load) begin
					bk_busy    <= 1'b1;
					loading    <= 1'b1;
					sd_req.lba <= 32'd0;
					sd_req.rd  <= 1'b1;
					sd_req.wr  <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_req.lba >= last_lba) begin
					bk_busy <= 1'b0;
					loading <= 1'b0;
				end else begin
					sd_req.lba <= sd_req.lba + 32'd1;
					sd_req.rd  <= loading;
					sd_req.wr  <= ~loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/cart_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int BSRAM_ADDR_W = 17
) (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  link_pkg::dl_word_t                 dl,
	input  logic [7:0]                         dl_index,
	input  logic                               dl_active,
	input  cart_pkg::hdr_mode_t                hdr_mode,
	input  cart_pkg::region_sel_t              region_sel,
	input  cart_pkg::bsram_port_t              bsram,
	output logic [7:0]                         bsram_q,
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic                               img_size_nz,
	input  logic                               bk_load,
	input  logic                               bk_save,
	input  logic                               autosave,
	input  logic                               osd_status,
	output link_pkg::sd_req_t                  sd_req,
	input  logic                               sd_ack,
	input  logic [link_pkg::SECTOR_ADDR_W-1:0] sd_buff_addr,
	input  logic [15:0]                        sd_buff_dout,
	input  logic                               sd_buff_wr,
	output logic [15:0]                        sd_buff_din,
	output cart_pkg::cart_info_t               cart_info,
	output link_pkg::cheat_code_t              cheat,
	output logic                               cheat_valid,
	output logic                               bk_ena,
	output logic                               bk_pending,
	output logic                               bk_busy
);

	link_pkg::dl_word_t cart_dl;
	link_pkg::dl_word_t code_dl;
	logic               cart_busy;
	logic               cart_start;
	logic               cart_end;

	download_port u_download_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.dl_index   (dl_index),
		.dl_active  (dl_active),
		.cart_dl    (cart_dl),
		.code_dl    (code_dl),
		.cart_busy  (cart_busy),
		.cart_start (cart_start),
		.cart_end   (cart_end)
	);

	rom_header_detect u_rom_header_detect (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_dl    (cart_dl),
		.cart_busy  (cart_busy),
		.hdr_mode   (hdr_mode),
		.region_sel (region_sel),
		.cart_info  (cart_info)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.code_dl     (code_dl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid)
	);

	backup_ram #(
		.BSRAM_ADDR_W (BSRAM_ADDR_W)
	) u_backup_ram (
		.clk_sys      (clk_sys),
		.cart_dl      (cart_dl),
		.cart_busy    (cart_busy),
		.bsram        (bsram),
		.bsram_q      (bsram_q),
		.sd_lba       (sd_req.lba),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din)
	);

	backup_sequencer u_backup_sequencer (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_busy    (cart_busy),
		.cart_start   (cart_start),
		.cart_end     (cart_end),
		.ram_mask     (cart_info.ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.bsram_we     (bsram.we),
		.sd_ack       (sd_ack),
		.sd_req       (sd_req),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.bk_busy      (bk_busy)
	);

endmodule

`default_nettype wire

/* test/tb_cart_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader;

	localparam int BSRAM_ADDR_W = 17;
	localparam int ACK_MAX      = 16;
	localparam int RAM_BYTES    = 8192;
	localparam int IMG_WORDS    = RAM_BYTES / 2;
	localparam int DL_WORDS     = 16 + 24 + IMG_WORDS + 8;
	localparam int SECTORS      = 32;
	localparam int CONSOLE_OPS  = RAM_BYTES * 3 + 1024;
	// Downloads, sector transfers at worst-case acknowledge delay and console traffic, doubled
	localparam int WATCH_CYCLES = 2 * (DL_WORDS + SECTORS * (ACK_MAX + 264) + CONSOLE_OPS) + 64;

	logic                            clk_sys;
	logic                            RESET;
	link_pkg::dl_word_t              dl;
	logic [7:0]                      dl_index;
	logic                            dl_active;
	cart_pkg::hdr_mode_t             hdr_mode;
	cart_pkg::region_sel_t           region_sel;
	cart_pkg::bsram_port_t           bsram;
	logic [7:0]                      bsram_q;
	logic                            img_mounted;
	logic                            img_readonly;
	logic                            img_size_nz;
	logic                            bk_load;
	logic                            bk_save;
	logic                            autosave;
	logic                            osd_status;
	link_pkg::sd_req_t               sd_req;
	logic                            sd_ack;
	logic [link_pkg::SECTOR_ADDR_W-1:0] sd_buff_addr;
	logic [15:0]                     sd_buff_dout;
	logic                            sd_buff_wr;
	logic [15:0]                     sd_buff_din;
	cart_pkg::cart_info_t            cart_info;
	link_pkg::cheat_code_t           cheat;
	logic                            cheat_valid;
	logic                            bk_ena;
	logic                            bk_pending;
	logic                            bk_busy;

	integer seed = 32'hac60a5f1;
	int     checks;
	int     errors;
	int     test_errs;
	int     cheat_pulses;
	int     sectors_seen;
	logic [31:0] lba_expect;

	// SD image and the bytes the console is expected to hold
	logic [15:0] img [IMG_WORDS];
	logic [7:0]  ram_ref [RAM_BYTES];

	link_pkg::cheat_code_t cheat_exp [$];

	cart_loader_top #(
		.BSRAM_ADDR_W (BSRAM_ADDR_W)
	) u_dut (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.dl_index     (dl_index),
		.dl_active    (dl_active),
		.hdr_mode     (hdr_mode),
		.region_sel   (region_sel),
		.bsram        (bsram),
		.bsram_q      (bsram_q),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.sd_req       (sd_req),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din),
		.cart_info    (cart_info),
		.cheat        (cheat),
		.cheat_valid  (cheat_valid),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.bk_busy      (bk_busy)
	);

	always #4 clk_sys = ~clk_sys;

	// ============================================================
	// Reference models
	// ============================================================

	function automatic logic [23:0] mask_ref(input logic [3:0] size, input logic is_ram);
		logic [23:0] m;
		m = 24'd1024;
		m = m << size;
		m = m - 24'd1;
		if (is_ram && size == 4'd0)
			m = 24'd0;
		return m;
	endfunction

	function automatic cart_pkg::cart_info_t header_ref(input cart_pkg::hdr_mode_t mode,
			input cart_pkg::region_sel_t rsel, input logic [15:0] w0,
			input logic [15:0] w2, input logic [15:0] rom_w, input logic [15:0] ram_w);
		cart_pkg::cart_info_t r;
		logic [3:0] rom_s;
		logic [3:0] ram_s;
		rom_s = 4'hC;
		ram_s = 4'd0;
		if (mode == cart_pkg::HDR_AUTO && w0[7:0] != 8'd0) begin
			rom_s = w0[3:0];
			ram_s = w0[7:4];
		end
		case (mode)
			cart_pkg::HDR_AUTO:    r.rom_type = w0[15:8];
			cart_pkg::HDR_HIROM:   r.rom_type = 8'd1;
			cart_pkg::HDR_EXHIROM: r.rom_type = 8'd2;
			default:               r.rom_type = 8'd0;
		endcase
		// Internal header words only count in a forced mode
		if (mode == cart_pkg::HDR_HIROM || mode == cart_pkg::HDR_EXHIROM ||
				mode == cart_pkg::HDR_LOROM) begin
			rom_s = rom_w[11:8];
			ram_s = ram_w[3:0];
		end
		r.rom_mask = mask_ref(rom_s, 1'b0);
		r.ram_mask = mask_ref(ram_s, 1'b1);
		if (rsel == cart_pkg::REGION_AUTO)
			r.pal = w2[8];
		else
			r.pal = (rsel == cart_pkg::REGION_PAL);
		return r;
	endfunction

	function automatic link_pkg::cheat_code_t cheat_ref(input logic [7:0][15:0] w);
		link_pkg::cheat_code_t c;
		c.flags   = {w[1], w[0]};
		c.addr    = {w[3], w[2]};
		c.compare = {w[5], w[4]};
		c.replace = {w[7], w[6]};
		return c;
	endfunction

	// ============================================================
	// Compare tasks
	// ============================================================

	task automatic fail(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_info(input string name, input cart_pkg::cart_info_t got,
			input cart_pkg::cart_info_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_cheat(input string name, input link_pkg::cheat_code_t got,
			input link_pkg::cheat_code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_lba(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic test_done(input string name);
		$display("%s: %0d errors", name, errors - test_errs);
		test_errs = errors;
	endtask

	// ============================================================
	// Stimulus helpers
	// ============================================================

	task automatic dl_begin(input logic [7:0] index);
		@(posedge clk_sys);
		dl_index  <= index;
		dl_active <= 1'b1;
	endtask

	task automatic dl_write(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl <= '{addr: addr, data: data, wr: 1'b1};
	endtask

	task automatic dl_finish();
		@(posedge clk_sys);
		dl        <= '{addr: 25'd0, data: 16'd0, wr: 1'b0};
		dl_active <= 1'b0;
	endtask

	task automatic settle(input int n);
		repeat (n) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic console_write(input logic [19:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		bsram <= '{addr: addr, data: data, we: 1'b1};
	endtask

	task automatic console_read(input logic [19:0] addr, output logic [7:0] q);
		@(posedge clk_sys);
		bsram <= '{addr: addr, data: 8'h00, we: 1'b0};
		@(posedge clk_sys);
		@(negedge clk_sys);
		q = bsram_q;
	endtask

	task automatic wait_transfer();
		@(negedge clk_sys);
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	// ============================================================
	// Cheat record compare and SD image model
	// ============================================================

	always @(negedge clk_sys) begin
		if (cheat_valid === 1'b1) begin
			cheat_pulses++;
			if (cheat_exp.size() == 0)
				fail("cheat_valid pulsed with no cheat record outstanding");
			else
				check_cheat("cheat", cheat, cheat_exp.pop_front());
		end
	end

	initial begin : sd_model
		logic [31:0] lba;
		logic        is_rd;
		int          delay;
		forever begin
			@(negedge clk_sys);
			if (RESET === 1'b0 && (sd_req.rd === 1'b1 || sd_req.wr === 1'b1)) begin
				lba   = sd_req.lba;
				is_rd = sd_req.rd;
				check_lba("sd_req.lba", lba, lba_expect);
				lba_expect++;
				sectors_seen++;
				delay = 1 + ($unsigned($random(seed)) % ACK_MAX);
				repeat (delay) @(posedge clk_sys);
				sd_ack <= 1'b1;
				if (is_rd) begin
					for (int w = 0; w < link_pkg::SECTOR_WORDS; w++) begin
						@(posedge clk_sys);
						sd_buff_addr <= w[7:0];
						sd_buff_dout <= img[{lba[3:0], w[7:0]}];
						sd_buff_wr   <= 1'b1;
					end
					@(posedge clk_sys);
					sd_buff_wr <= 1'b0;
				end else begin
					// Read data trails the buffer address by one cycle
					for (int w = 0; w <= link_pkg::SECTOR_WORDS; w++) begin
						@(posedge clk_sys);
						if (w < link_pkg::SECTOR_WORDS)
							sd_buff_addr <= w[7:0];
						@(negedge clk_sys);
						if (w > 0)
							img[{lba[3:0], 8'(w - 1)}] = sd_buff_din;
					end
				end
				@(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (WATCH_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not complete", WATCH_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin : main
		cart_pkg::cart_info_t exp;
		logic [15:0]          w0;
		logic [15:0]          w2;
		logic [15:0]          rom_w;
		logic [15:0]          ram_w;
		logic [7:0][15:0]     rec;
		logic [7:0]           q;
		logic [7:0]           b;

		clk_sys      = 1'b0;
		RESET        = 1'b1;
		dl           = '{addr: 25'd0, data: 16'd0, wr: 1'b0};
		dl_index     = 8'd0;
		dl_active    = 1'b0;
		hdr_mode     = cart_pkg::HDR_AUTO;
		region_sel   = cart_pkg::REGION_AUTO;
		bsram        = '{addr: 20'd0, data: 8'd0, we: 1'b0};
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		osd_status   = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = 16'd0;
		sd_buff_wr   = 1'b0;
		checks       = 0;
		errors       = 0;
		test_errs    = 0;
		cheat_pulses = 0;
		sectors_seen = 0;
		lba_expect   = 32'd0;

		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;

		// Handshake and status outputs come out of reset low
		@(negedge clk_sys);
		if (sd_req.rd !== 1'b0 || sd_req.wr !== 1'b0 || bk_busy !== 1'b0 ||
				bk_pending !== 1'b0 || bk_ena !== 1'b0 || cheat_valid !== 1'b0)
			fail("request, busy, pending, enable or cheat_valid not low after reset");
		test_done("reset values");

		// Copier header in auto mode
		w0 = $random(seed);
		if (w0[7:0] == 8'd0)
			w0[7:0] = 8'h01;
		w2 = $random(seed) | 16'h0100;
		dl_begin(8'd0);
		dl_write(25'd0, w0);
		dl_write(25'd2, w2);
		settle(2);
		exp = header_ref(cart_pkg::HDR_AUTO, cart_pkg::REGION_AUTO, w0, w2, 16'd0, 16'd0);
		// Region is still frozen at its reset value
		exp.pal = 1'b0;
		check_info("cart_info", cart_info, exp);
		for (int a = 4; a < 16; a += 2)
			dl_write(a[24:0], $random(seed));
		dl_finish();
		settle(3);
		exp = header_ref(cart_pkg::HDR_AUTO, cart_pkg::REGION_AUTO, w0, w2, 16'd0, 16'd0);
		check_info("cart_info", cart_info, exp);
		test_done("test 1 copier header");

		// Forced HiROM with PAL, then ExHiROM with NTSC
		for (int m = 0; m < 2; m++) begin
			@(posedge clk_sys);
			hdr_mode   <= (m == 0) ? cart_pkg::HDR_HIROM : cart_pkg::HDR_EXHIROM;
			region_sel <= (m == 0) ? cart_pkg::REGION_PAL : cart_pkg::REGION_NTSC;
			w0    = $random(seed);
			w2    = $random(seed) & 16'hFEFF;
			rom_w = $random(seed);
			ram_w = $random(seed);
			dl_begin(8'd1);
			dl_write(25'd0, w0);
			dl_write(25'd2, w2);
			dl_write((m == 0) ? cart_pkg::HIROM_HDR : cart_pkg::EXHIROM_HDR, rom_w);
			dl_write(((m == 0) ? cart_pkg::HIROM_HDR : cart_pkg::EXHIROM_HDR) + 25'd2, ram_w);
			dl_finish();
			settle(3);
			exp = header_ref(hdr_mode, region_sel, w0, w2, rom_w, ram_w);
			check_info("cart_info", cart_info, exp);
		end
		@(posedge clk_sys);
		hdr_mode   <= cart_pkg::HDR_AUTO;
		region_sel <= cart_pkg::REGION_AUTO;
		test_done("test 2 forced header modes");

		// Cheat records
		dl_begin(link_pkg::CODE_INDEX);
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 8; i++)
				rec[i] = $random(seed);
			cheat_exp.push_back(cheat_ref(rec));
			for (int i = 0; i < 8; i++)
				dl_write(25'(k * 16 + i * 2), rec[i]);
		end
		dl_finish();
		settle(4);
		if (cheat_pulses != 3)
			fail($sformatf("expected 3 cheat_valid pulses, saw %0d", cheat_pulses));
		if (cheat_exp.size() != 0)
			fail("a cheat record never produced a cheat_valid pulse");
		test_done("test 3 cheat records");

		// Cartridge with 8 KB of backup RAM, writable image mounted
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		dl_begin(8'd0);
		dl_write(25'd0, 16'h0038);
		dl_write(25'd2, 16'h0000);
		for (int a = 4; a < RAM_BYTES; a += 2)
			dl_write(a[24:0], $random(seed));
		dl_finish();
		settle(3);
		if (bk_ena !== 1'b1)
			fail("bk_ena did not rise for a cartridge with backup RAM");
		for (int a = 0; a < RAM_BYTES; a += 34) begin
			console_read(a[19:0], q);
			check_byte("bsram_q", q, 8'hFF);
		end
		for (int a = 0; a < RAM_BYTES; a++) begin
			b = $random(seed);
			ram_ref[a] = b;
			console_write(a[19:0], b);
		end
		@(posedge clk_sys);
		bsram.we <= 1'b0;
		settle(1);
		if (bk_pending !== 1'b1)
			fail("bk_pending stayed low after console writes");
		test_done("test 4 backup fill and pending");

		// Save 16 sectors to the image
		lba_expect   = 32'd0;
		sectors_seen = 0;
		@(posedge clk_sys);
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		wait_transfer();
		if (sectors_seen != 16)
			fail($sformatf("save moved %0d sectors instead of 16", sectors_seen));
		for (int w = 0; w < IMG_WORDS; w++) begin
			check_byte("img low byte", img[w][7:0], ram_ref[2 * w]);
			check_byte("img high byte", img[w][15:8], ram_ref[2 * w + 1]);
		end
		test_done("test 5 sector save");

		// New image contents, loaded by the next cartridge download
		for (int w = 0; w < IMG_WORDS; w++) begin
			img[w]             = $random(seed);
			ram_ref[2 * w]     = img[w][7:0];
			ram_ref[2 * w + 1] = img[w][15:8];
		end
		lba_expect   = 32'd0;
		sectors_seen = 0;
		@(posedge clk_sys);
		img_size_nz <= 1'b1;
		dl_begin(8'd0);
		dl_write(25'd0, 16'h0038);
		dl_write(25'd2, 16'h0000);
		dl_finish();
		wait_transfer();
		if (sectors_seen != 16)
			fail($sformatf("auto load moved %0d sectors instead of 16", sectors_seen));
		for (int a = 0; a < RAM_BYTES; a++) begin
			console_read(a[19:0], q);
			check_byte("bsram_q", q, ram_ref[a]);
		end
		test_done("test 6 automatic load");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hw/cart_pkg.sv
hw/link_pkg.sv
hw/download_port.sv
hw/rom_header_detect.sv
hw/cheat_code_assembler.sv
hw/backup_ram.sv
hw/backup_sequencer.sv
hw/cart_loader_top.sv
test/tb_cart_loader.sv
